//--- cam_pkg.sv
// Camera capture package
// Bus and FIFO widths, register map and fixed register values
// shared by the packer, the FIFO bank and the register bank

package cam_pkg;

    // ------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------
    localparam int ADDR_W = 9;          // Room for 512 bus addresses
    localparam int DATA_W = 32;
    localparam int PIX_W  = 8;          // One camera byte
    localparam int GPIO_W = 8;

    // ------------------------------------------------------------
    // FIFO sizing
    // ------------------------------------------------------------
    localparam int FIFO_DEPTH = 16;
    localparam int CNT_W      = 5;      // Holds 0 up to FIFO_DEPTH
    localparam int NUM_FIFO   = 3;

    // Steering counter covers all three FIFOs in turn
    localparam int STEER_W = $clog2(NUM_FIFO * FIFO_DEPTH);
    localparam logic [STEER_W-1:0] STEER_LAST = STEER_W'(NUM_FIFO * FIFO_DEPTH - 1);

    // ------------------------------------------------------------
    // Register map
    // ------------------------------------------------------------
    localparam logic [ADDR_W-1:0] ADR_DEV_ID   = 9'h000;
    localparam logic [ADDR_W-1:0] ADR_REV      = 9'h001;
    localparam logic [ADDR_W-1:0] ADR_GPIO_IN  = 9'h002;
    localparam logic [ADDR_W-1:0] ADR_GPIO_OUT = 9'h003;
    localparam logic [ADDR_W-1:0] ADR_GPIO_OE  = 9'h004;

    // Access address pops one word, flag address is read only
    localparam logic [ADDR_W-1:0] ADR_FIFO1_ACC  = 9'h040;
    localparam logic [ADDR_W-1:0] ADR_FIFO1_FLAG = 9'h041;
    localparam logic [ADDR_W-1:0] ADR_FIFO2_ACC  = 9'h080;
    localparam logic [ADDR_W-1:0] ADR_FIFO2_FLAG = 9'h081;
    localparam logic [ADDR_W-1:0] ADR_FIFO3_ACC  = 9'h100;
    localparam logic [ADDR_W-1:0] ADR_FIFO3_FLAG = 9'h101;

    // ------------------------------------------------------------
    // Fixed register values
    // ------------------------------------------------------------
    localparam logic [DATA_W-1:0] DEVICE_ID     = 32'hF1F0_7E57;
    localparam logic [15:0]       REV_NUM       = 16'h0100;
    localparam logic [DATA_W-1:0] DEF_REG_VALUE = 32'hFABD_EFAC;  // Unmapped reads

    // Flag word layout, count sits in bits 4 to 0
    localparam int FLAG_EMPTY_BIT = 8;
    localparam int FLAG_FULL_BIT  = 9;
    localparam int FLAG_OVF_BIT   = 10;

endpackage

//--- pixel_packer.sv
// Camera byte packer
// Collects bytes qualified by vsync and href into 32-bit words,
// first byte in the low lane, and strobes each finished word

`timescale 1ns/1ps

module pixel_packer (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic [cam_pkg::PIX_W-1:0]   cam_data_i,
    input  logic                        vsync_i,
    input  logic                        href_i,
    output logic [cam_pkg::DATA_W-1:0]  word_o,
    output logic                        word_valid_o
);

    logic [1:0]                   lane_q;     // Byte lane of the next byte
    logic [cam_pkg::DATA_W-1:0]   shift_q;
    logic                         byte_ok;

    assign byte_ok = vsync_i & href_i;

    // ------------------------------------------------------------
    // Lane state and word strobe
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            lane_q       <= 2'd0;
            word_valid_o <= 1'b0;
        end
        else
        begin
            word_valid_o <= 1'b0;
            if (!vsync_i)
            begin
                lane_q <= 2'd0;                 // Frame gap drops a partial word
            end
            else if (byte_ok)
            begin
                lane_q <= lane_q + 2'd1;        // Wraps after the fourth byte
                if (lane_q == 2'd3)
                    word_valid_o <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Byte shifter
    // ------------------------------------------------------------
    // New bytes enter at the top, so the first byte of a word
    // has moved down to bits 7 to 0 once the fourth one arrives
    always_ff @(posedge clk_i)
    begin
        if (byte_ok)
        begin
            shift_q <= {cam_data_i, shift_q[cam_pkg::DATA_W-1:cam_pkg::PIX_W]};
            if (lane_q == 2'd3)
                word_o <= {cam_data_i, shift_q[cam_pkg::DATA_W-1:cam_pkg::PIX_W]};
        end
    end

endmodule

//--- word_fifo.sv
// Synchronous word FIFO
// FIFO_DEPTH entries with occupancy count, empty and full flags,
// and an overflow flag that holds until reset

`timescale 1ns/1ps

module word_fifo (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        push_i,
    input  logic [cam_pkg::DATA_W-1:0]  data_i,
    input  logic                        pop_i,
    output logic [cam_pkg::DATA_W-1:0]  head_o,
    output logic [cam_pkg::CNT_W-1:0]   count_o,
    output logic                        empty_o,
    output logic                        full_o,
    output logic                        ovf_o
);

    logic [cam_pkg::DATA_W-1:0]   mem_q [cam_pkg::FIFO_DEPTH];
    logic [cam_pkg::CNT_W-2:0]    wr_ptr_q;   // Wraps at FIFO_DEPTH
    logic [cam_pkg::CNT_W-2:0]    rd_ptr_q;
    logic [cam_pkg::CNT_W-1:0]    count_q;
    logic                         ovf_q;
    logic                         push_ok;
    logic                         pop_ok;

    // Depth is a power of two, count MSB alone means full
    assign full_o  = count_q[cam_pkg::CNT_W-1];
    assign empty_o = (count_q == '0);

    assign push_ok = push_i & ~full_o;
    assign pop_ok  = pop_i & ~empty_o;

    // ------------------------------------------------------------
    // Pointers, count and overflow
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            ovf_q    <= 1'b0;
        end
        else
        begin
            if (push_ok)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop_ok)
                rd_ptr_q <= rd_ptr_q + 1'b1;

            case ({push_ok, pop_ok})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;    // Idle or both at once
            endcase

            if (push_i && full_o)
                ovf_q <= 1'b1;                  // Word lost
        end
    end

    // Storage
    always_ff @(posedge clk_i)
    begin
        if (push_ok)
            mem_q[wr_ptr_q] <= data_i;
    end

    assign head_o  = empty_o ? '0 : mem_q[rd_ptr_q];   // Oldest word
    assign count_o = count_q;
    assign ovf_o   = ovf_q;

endmodule

//--- fifo_bank.sv
// Three-FIFO capture bank
// Steers packed words into the FIFOs in blocks of FIFO_DEPTH words,
// wrapping back to the first, and passes bus pops to each FIFO

`timescale 1ns/1ps

module fifo_bank (
    input  logic                                                clk_i,
    input  logic                                                rst_i,
    input  logic [cam_pkg::DATA_W-1:0]                          word_i,
    input  logic                                                word_valid_i,
    input  logic [cam_pkg::NUM_FIFO-1:0]                        pop_i,
    output logic [cam_pkg::NUM_FIFO-1:0][cam_pkg::DATA_W-1:0]   head_o,
    output logic [cam_pkg::NUM_FIFO-1:0][cam_pkg::CNT_W-1:0]    count_o,
    output logic [cam_pkg::NUM_FIFO-1:0]                        empty_o,
    output logic [cam_pkg::NUM_FIFO-1:0]                        full_o,
    output logic [cam_pkg::NUM_FIFO-1:0]                        ovf_o
);

    logic [cam_pkg::STEER_W-1:0]              steer_q;
    logic [cam_pkg::STEER_W-cam_pkg::CNT_W:0] sel;     // Target FIFO index
    logic [cam_pkg::NUM_FIFO-1:0]             push;

    // ------------------------------------------------------------
    // Steering counter
    // ------------------------------------------------------------
    // Advances on every word, stored or dropped
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            steer_q <= '0;
        end
        else if (word_valid_i)
        begin
            if (steer_q == cam_pkg::STEER_LAST)
                steer_q <= '0;
            else
                steer_q <= steer_q + 1'b1;
        end
    end

    // Upper counter bits count whole FIFO blocks
    assign sel = steer_q[cam_pkg::STEER_W-1:cam_pkg::CNT_W-1];

    always_comb
    begin
        push = '0;
        if (word_valid_i)
            push[sel] = 1'b1;
    end

    // ------------------------------------------------------------
    // FIFO instances
    // ------------------------------------------------------------
    for (genvar i = 0; i < cam_pkg::NUM_FIFO; i++)
    begin : g_fifo
        word_fifo i_word_fifo (
            .clk_i   (clk_i),
            .rst_i   (rst_i),
            .push_i  (push[i]),
            .data_i  (word_i),
            .pop_i   (pop_i[i]),        // Bus pop goes straight through
            .head_o  (head_o[i]),
            .count_o (count_o[i]),
            .empty_o (empty_o[i]),
            .full_o  (full_o[i]),
            .ovf_o   (ovf_o[i])
        );
    end

endmodule

//--- wb_regs.sv
// Wishbone register bank
// Single-cycle acknowledge, GPIO output and enable registers,
// FIFO pop requests and the combinational read multiplexer

`timescale 1ns/1ps

module wb_regs (
    input  logic                                                clk_i,
    input  logic                                                rst_i,
    input  logic [cam_pkg::ADDR_W-1:0]                          wbs_adr_i,
    input  logic                                                wbs_cyc_i,
    input  logic                                                wbs_stb_i,
    input  logic                                                wbs_we_i,
    input  logic [3:0]                                          wbs_byte_stb_i,
    input  logic [cam_pkg::DATA_W-1:0]                          wbs_dat_i,
    output logic [cam_pkg::DATA_W-1:0]                          wbs_dat_o,
    output logic                                                wbs_ack_o,
    input  logic [cam_pkg::GPIO_W-1:0]                          gpio_in_i,
    output logic [cam_pkg::GPIO_W-1:0]                          gpio_out_o,
    output logic [cam_pkg::GPIO_W-1:0]                          gpio_oe_o,
    input  logic [cam_pkg::NUM_FIFO-1:0][cam_pkg::DATA_W-1:0]   head_i,
    input  logic [cam_pkg::NUM_FIFO-1:0][cam_pkg::CNT_W-1:0]    count_i,
    input  logic [cam_pkg::NUM_FIFO-1:0]                        empty_i,
    input  logic [cam_pkg::NUM_FIFO-1:0]                        full_i,
    input  logic [cam_pkg::NUM_FIFO-1:0]                        ovf_i,
    output logic [cam_pkg::NUM_FIFO-1:0]                        pop_o,
    output logic [cam_pkg::DATA_W-1:0]                          device_id_o
);

    logic                         ack_nxt;
    logic                         wr_stb;     // First cycle of a write
    logic                         rd_stb;     // First cycle of a read
    logic [cam_pkg::NUM_FIFO-1:0] acc_hit;

    // Packs count and status bits of one FIFO
    function automatic logic [cam_pkg::DATA_W-1:0] flag_word(
        input logic [cam_pkg::CNT_W-1:0] cnt,
        input logic                      emp,
        input logic                      ful,
        input logic                      ovf
    );
        logic [cam_pkg::DATA_W-1:0] w;
        w = '0;
        w[cam_pkg::CNT_W-1:0]      = cnt;
        w[cam_pkg::FLAG_EMPTY_BIT] = emp;
        w[cam_pkg::FLAG_FULL_BIT]  = ful;
        w[cam_pkg::FLAG_OVF_BIT]   = ovf;
        return w;
    endfunction

    // ------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------
    assign ack_nxt = wbs_cyc_i & wbs_stb_i & ~wbs_ack_o;    // One ack per access
    assign wr_stb  = ack_nxt & wbs_we_i;
    assign rd_stb  = ack_nxt & ~wbs_we_i;

    assign acc_hit[0] = (wbs_adr_i == cam_pkg::ADR_FIFO1_ACC);
    assign acc_hit[1] = (wbs_adr_i == cam_pkg::ADR_FIFO2_ACC);
    assign acc_hit[2] = (wbs_adr_i == cam_pkg::ADR_FIFO3_ACC);

    // ------------------------------------------------------------
    // Ack, GPIO registers and pops
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            wbs_ack_o  <= 1'b0;
            gpio_out_o <= '0;
            gpio_oe_o  <= '0;
            pop_o      <= '0;
        end
        else
        begin
            wbs_ack_o <= ack_nxt;

            if (wr_stb && wbs_byte_stb_i[0])
            begin
                if (wbs_adr_i == cam_pkg::ADR_GPIO_OUT)
                    gpio_out_o <= wbs_dat_i[cam_pkg::GPIO_W-1:0];
                if (wbs_adr_i == cam_pkg::ADR_GPIO_OE)
                    gpio_oe_o <= wbs_dat_i[cam_pkg::GPIO_W-1:0];
            end

            // High during the ack cycle, the word leaves at its end
            pop_o <= acc_hit & ~empty_i & {cam_pkg::NUM_FIFO{rd_stb}};
        end
    end

    // ------------------------------------------------------------
    // Read multiplexer
    // ------------------------------------------------------------
    always_comb
    begin
        case (wbs_adr_i)
            cam_pkg::ADR_DEV_ID:     wbs_dat_o = cam_pkg::DEVICE_ID;
            cam_pkg::ADR_REV:        wbs_dat_o = {16'h0, cam_pkg::REV_NUM};
            cam_pkg::ADR_GPIO_IN:
                wbs_dat_o = {{(cam_pkg::DATA_W - cam_pkg::GPIO_W){1'b0}}, gpio_in_i};
            cam_pkg::ADR_GPIO_OUT:
                wbs_dat_o = {{(cam_pkg::DATA_W - cam_pkg::GPIO_W){1'b0}}, gpio_out_o};
            cam_pkg::ADR_GPIO_OE:
                wbs_dat_o = {{(cam_pkg::DATA_W - cam_pkg::GPIO_W){1'b0}}, gpio_oe_o};
            cam_pkg::ADR_FIFO1_ACC:  wbs_dat_o = head_i[0];     // Zero when empty
            cam_pkg::ADR_FIFO1_FLAG:
                wbs_dat_o = flag_word(count_i[0], empty_i[0], full_i[0], ovf_i[0]);
            cam_pkg::ADR_FIFO2_ACC:  wbs_dat_o = head_i[1];
            cam_pkg::ADR_FIFO2_FLAG:
                wbs_dat_o = flag_word(count_i[1], empty_i[1], full_i[1], ovf_i[1]);
            cam_pkg::ADR_FIFO3_ACC:  wbs_dat_o = head_i[2];
            cam_pkg::ADR_FIFO3_FLAG:
                wbs_dat_o = flag_word(count_i[2], empty_i[2], full_i[2], ovf_i[2]);
            default:                 wbs_dat_o = cam_pkg::DEF_REG_VALUE;
        endcase
    end

    assign device_id_o = cam_pkg::DEVICE_ID;

endmodule

//--- cam_fifo_top.sv
// Camera capture top level
// Camera byte packer feeding a three-FIFO bank, read out through
// the Wishbone register bank, all on the pixel clock

`timescale 1ns/1ps

module cam_fifo_top (
    input  logic                        PCLKI,
    input  logic                        WBs_RST_i,
    // Wishbone
    input  logic [cam_pkg::ADDR_W-1:0]  wbs_adr_i,
    input  logic                        wbs_cyc_i,
    input  logic                        wbs_stb_i,
    input  logic                        wbs_we_i,
    input  logic [3:0]                  wbs_byte_stb_i,
    input  logic [cam_pkg::DATA_W-1:0]  wbs_dat_i,
    output logic [cam_pkg::DATA_W-1:0]  wbs_dat_o,
    output logic                        wbs_ack_o,
    // Camera
    input  logic [cam_pkg::PIX_W-1:0]   cam_data_i,
    input  logic                        vsync_i,
    input  logic                        href_i,
    // GPIO and ID
    input  logic [cam_pkg::GPIO_W-1:0]  gpio_in_i,
    output logic [cam_pkg::GPIO_W-1:0]  gpio_out_o,
    output logic [cam_pkg::GPIO_W-1:0]  gpio_oe_o,
    output logic [cam_pkg::DATA_W-1:0]  device_id_o
);

    logic [cam_pkg::DATA_W-1:0]                         word;
    logic                                               word_valid;
    logic [cam_pkg::NUM_FIFO-1:0][cam_pkg::DATA_W-1:0]  head;
    logic [cam_pkg::NUM_FIFO-1:0][cam_pkg::CNT_W-1:0]   count;
    logic [cam_pkg::NUM_FIFO-1:0]                       empty;
    logic [cam_pkg::NUM_FIFO-1:0]                       full;
    logic [cam_pkg::NUM_FIFO-1:0]                       ovf;
    logic [cam_pkg::NUM_FIFO-1:0]                       pop;

    pixel_packer i_pixel_packer (
        .clk_i        (PCLKI),
        .rst_i        (WBs_RST_i),
        .cam_data_i   (cam_data_i),
        .vsync_i      (vsync_i),
        .href_i       (href_i),
        .word_o       (word),
        .word_valid_o (word_valid)
    );

    fifo_bank i_fifo_bank (
        .clk_i        (PCLKI),
        .rst_i        (WBs_RST_i),
        .word_i       (word),
        .word_valid_i (word_valid),
        .pop_i        (pop),
        .head_o       (head),
        .count_o      (count),
        .empty_o      (empty),
        .full_o       (full),
        .ovf_o        (ovf)
    );

    wb_regs i_wb_regs (
        .clk_i          (PCLKI),
        .rst_i          (WBs_RST_i),
        .wbs_adr_i      (wbs_adr_i),
        .wbs_cyc_i      (wbs_cyc_i),
        .wbs_stb_i      (wbs_stb_i),
        .wbs_we_i       (wbs_we_i),
        .wbs_byte_stb_i (wbs_byte_stb_i),
        .wbs_dat_i      (wbs_dat_i),
        .wbs_dat_o      (wbs_dat_o),
        .wbs_ack_o      (wbs_ack_o),
        .gpio_in_i      (gpio_in_i),
        .gpio_out_o     (gpio_out_o),
        .gpio_oe_o      (gpio_oe_o),
        .head_i         (head),
        .count_i        (count),
        .empty_i        (empty),
        .full_i         (full),
        .ovf_i          (ovf),
        .pop_o          (pop),
        .device_id_o    (device_id_o)
    );

endmodule

//--- tb_cam_fifo_assert.sv
// Bus and FIFO property checks
// Bound into the register bank and into every word FIFO

`timescale 1ns/1ps

module tb_cam_fifo_assert (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       ack_i,
    input  logic                       pop_i,
    input  logic                       empty_i,
    input  logic [cam_pkg::CNT_W-1:0]  count_i
);

    logic ack_bad = 1'b0;
    logic pop_bad = 1'b0;
    logic cnt_bad = 1'b0;
    logic failed;

    assign failed = ack_bad | pop_bad | cnt_bad;

    // Ack is a one-cycle pulse
    a_ack_single: assert property (@(posedge clk_i) disable iff (rst_i) ack_i |=> !ack_i)
    else
    begin
        ack_bad = 1'b1;
        $error("wbs_ack_o stayed high for two cycles");
    end

    a_pop_not_empty: assert property (@(posedge clk_i) disable iff (rst_i)
        !(pop_i && empty_i))
    else
    begin
        pop_bad = 1'b1;
        $error("FIFO popped while empty");
    end

    a_count_max: assert property (@(posedge clk_i) disable iff (rst_i)
        count_i <= cam_pkg::CNT_W'(cam_pkg::FIFO_DEPTH))
    else
    begin
        cnt_bad = 1'b1;
        $error("FIFO count above FIFO_DEPTH");
    end

endmodule

// Register bank checks only the ack
bind wb_regs tb_cam_fifo_assert i_bus_assert (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .ack_i   (wbs_ack_o),
    .pop_i   (1'b0),
    .empty_i (1'b0),
    .count_i ({cam_pkg::CNT_W{1'b0}})
);

bind word_fifo tb_cam_fifo_assert i_fifo_assert (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .ack_i   (1'b0),
    .pop_i   (pop_i),
    .empty_i (empty_o),
    .count_i (count_o)
);

//--- tb_cam_fifo.sv
// Testbench for the camera capture block
// Applies a table of bus accesses and camera bursts, and checks the
// reads against a queue model of the three FIFOs

`timescale 1ns/1ps

module tb_cam_fifo;

    localparam int ACK_LIMIT = 20;          // Cycles allowed for one bus ack
    localparam logic [3:0] OP_WR   = 4'd0;
    localparam logic [3:0] OP_RD   = 4'd1;  // Fixed expected value
    localparam logic [3:0] OP_RDM  = 4'd2;  // Expected value from the model
    localparam logic [3:0] OP_CAM  = 4'd3;
    localparam logic [3:0] OP_GPIO = 4'd4;  // Port check, oe in dat[15:8]

    typedef struct packed {
        logic [3:0]  op;
        logic [8:0]  adr;
        logic [3:0]  strb;
        logic [31:0] dat;                   // Write data or expected value
        logic [7:0]  n;                     // Words per burst or reads in a row
    } step_t;

    logic                        PCLKI;
    logic                        WBs_RST_i;
    logic [cam_pkg::ADDR_W-1:0]  wbs_adr_i;
    logic                        wbs_cyc_i;
    logic                        wbs_stb_i;
    logic                        wbs_we_i;
    logic [3:0]                  wbs_byte_stb_i;
    logic [cam_pkg::DATA_W-1:0]  wbs_dat_i;
    logic [cam_pkg::DATA_W-1:0]  wbs_dat_o;
    logic                        wbs_ack_o;
    logic [cam_pkg::PIX_W-1:0]   cam_data_i;
    logic                        vsync_i;
    logic                        href_i;
    logic [cam_pkg::GPIO_W-1:0]  gpio_in_i;
    logic [cam_pkg::GPIO_W-1:0]  gpio_out_o;
    logic [cam_pkg::GPIO_W-1:0]  gpio_oe_o;
    logic [cam_pkg::DATA_W-1:0]  device_id_o;

    step_t                       steps [$];
    step_t                       st;
    logic [31:0]                 model_q [cam_pkg::NUM_FIFO][$];
    logic [cam_pkg::NUM_FIFO-1:0] model_ovf;
    int                          steer;     // Model steering counter
    logic [31:0]                 rnd_state;
    logic [31:0]                 rdata;
    logic [31:0]                 expv;

    cam_fifo_top i_cam_fifo_top (.*);

    initial
    begin
        PCLKI = 1'b0;
        forever #5 PCLKI = ~PCLKI;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Any bound bus or FIFO property that has failed so far
    function automatic logic bound_check_failed();
        return i_cam_fifo_top.i_wb_regs.i_bus_assert.failed
             | i_cam_fifo_top.i_fifo_bank.g_fifo[0].i_word_fifo.i_fifo_assert.failed
             | i_cam_fifo_top.i_fifo_bank.g_fifo[1].i_word_fifo.i_fifo_assert.failed
             | i_cam_fifo_top.i_fifo_bank.g_fifo[2].i_word_fifo.i_fifo_assert.failed;
    endfunction

    task automatic stop_run(input string why);
        $display("** FAIL **");
        $display("%s", why);
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want)
        else
            stop_run($sformatf("error at %0d ns: %s is 0x%08h, expected 0x%08h",
                               $time, name, got, want));
    endtask

    task automatic add_step(input logic [3:0] op, input logic [8:0] adr,
                            input logic [3:0] strb, input logic [31:0] dat, input int n);
        steps.push_back({op, adr, strb, dat, 8'(n)});
    endtask

    // ------------------------------------------------------------
    // Bus master, drives 1 ns after the edge and waits for ack
    // ------------------------------------------------------------
    task automatic bus_cycle(input logic [8:0] adr, input logic we, input logic [3:0] strb,
                             input logic [31:0] dat, output logic [31:0] rd);
        int waited;
        waited = 0;
        @(posedge PCLKI);
        #1;
        wbs_adr_i      = adr;
        wbs_we_i       = we;
        wbs_byte_stb_i = strb;
        wbs_dat_i      = dat;
        wbs_cyc_i      = 1'b1;
        wbs_stb_i      = 1'b1;
        while (wbs_ack_o !== 1'b1)
        begin
            if (waited == ACK_LIMIT)
                stop_run($sformatf("no bus acknowledge for address 0x%03h", adr));
            @(posedge PCLKI);
            #1;
            waited++;
        end
        rd        = wbs_dat_o;              // Sampled while ack is high
        wbs_cyc_i = 1'b0;
        wbs_stb_i = 1'b0;
        wbs_we_i  = 1'b0;
    endtask

    // ------------------------------------------------------------
    // Reference model of the FIFO bank
    // ------------------------------------------------------------
    task automatic model_push(input logic [31:0] w);
        int idx;
        idx = steer / cam_pkg::FIFO_DEPTH;
        if (model_q[idx].size() < cam_pkg::FIFO_DEPTH)
            model_q[idx].push_back(w);
        else
            model_ovf[idx] = 1'b1;          // Dropped, FIFO full
        steer = (steer + 1) % (cam_pkg::NUM_FIFO * cam_pkg::FIFO_DEPTH);
    endtask

    task automatic model_read(input logic [8:0] adr, output logic [31:0] want);
        int idx;
        idx  = (adr[8:6] == 3'b001) ? 0 : (adr[8:6] == 3'b010) ? 1 : 2;
        want = '0;
        if (adr[0] == 1'b0)
        begin
            if (model_q[idx].size() > 0)
                want = model_q[idx].pop_front();    // Empty FIFO reads as zero
        end
        else
        begin
            want[4:0] = 5'(model_q[idx].size());
            want[cam_pkg::FLAG_EMPTY_BIT] = (model_q[idx].size() == 0);
            want[cam_pkg::FLAG_FULL_BIT]  = (model_q[idx].size() == cam_pkg::FIFO_DEPTH);
            want[cam_pkg::FLAG_OVF_BIT]   = model_ovf[idx];
        end
    endtask

    // Four bytes per word, one idle href cycle between words
    task automatic cam_burst(input int words);
        logic [7:0] b [4];
        for (int w = 0; w < words; w++)
        begin
            for (int i = 0; i < 4; i++)
            begin
                rnd_state = xorshift32(rnd_state);
                b[i] = rnd_state[7:0];
                @(posedge PCLKI);
                #1;
                vsync_i    = 1'b1;
                href_i     = 1'b1;
                cam_data_i = b[i];
            end
            model_push({b[3], b[2], b[1], b[0]});
            @(posedge PCLKI);
            #1;
            href_i     = 1'b0;
            cam_data_i = rnd_state[15:8];   // Not qualified
        end
        vsync_i = 1'b0;
        repeat (3) @(posedge PCLKI);        // Last word lands two edges after its byte
    endtask

    initial
    begin
        WBs_RST_i      = 1'b1;
        wbs_adr_i      = '0;
        wbs_cyc_i      = 1'b0;
        wbs_stb_i      = 1'b0;
        wbs_we_i       = 1'b0;
        wbs_byte_stb_i = '0;
        wbs_dat_i      = '0;
        cam_data_i     = '0;
        vsync_i        = 1'b0;
        href_i         = 1'b0;
        gpio_in_i      = 8'hA5;
        model_ovf      = '0;
        steer          = 0;
        rnd_state      = 32'd55445;

        // Reset values and identification
        add_step(OP_RD, cam_pkg::ADR_DEV_ID, 4'hF, cam_pkg::DEVICE_ID, 1);
        add_step(OP_RD, cam_pkg::ADR_REV, 4'hF, {16'h0, cam_pkg::REV_NUM}, 1);
        add_step(OP_RD, cam_pkg::ADR_GPIO_IN, 4'hF, 32'h0000_00A5, 1);
        add_step(OP_RD, 9'h1FF, 4'hF, cam_pkg::DEF_REG_VALUE, 1);
        add_step(OP_GPIO, 9'h000, 4'h0, 32'h0000_0000, 1);
        // GPIO writes, only byte lane 0 counts
        add_step(OP_WR, cam_pkg::ADR_GPIO_OUT, 4'h1, 32'h0000_003C, 1);
        add_step(OP_WR, cam_pkg::ADR_GPIO_OE, 4'hF, 32'h0000_00F0, 1);
        add_step(OP_GPIO, 9'h000, 4'h0, 32'h0000_F03C, 1);
        add_step(OP_WR, cam_pkg::ADR_GPIO_OUT, 4'hE, 32'h0000_0055, 1);
        add_step(OP_WR, cam_pkg::ADR_GPIO_OE, 4'h0, 32'h0000_000F, 1);
        add_step(OP_GPIO, 9'h000, 4'h0, 32'h0000_F03C, 1);
        add_step(OP_RD, cam_pkg::ADR_GPIO_OUT, 4'hF, 32'h0000_003C, 1);
        add_step(OP_RD, cam_pkg::ADR_GPIO_OE, 4'hF, 32'h0000_00F0, 1);
        // Five words through FIFO 1, then empty reads
        add_step(OP_CAM, 9'h000, 4'h0, 32'h0, 5);
        add_step(OP_RDM, cam_pkg::ADR_FIFO1_FLAG, 4'hF, 32'h0, 1);
        add_step(OP_RDM, cam_pkg::ADR_FIFO1_ACC, 4'hF, 32'h0, 3);
        add_step(OP_RDM, cam_pkg::ADR_FIFO1_FLAG, 4'hF, 32'h0, 1);
        add_step(OP_RDM, cam_pkg::ADR_FIFO1_ACC, 4'hF, 32'h0, 2);
        add_step(OP_RD, cam_pkg::ADR_FIFO1_ACC, 4'hF, 32'h0000_0000, 1);
        add_step(OP_RD, cam_pkg::ADR_FIFO1_FLAG, 4'hF, 32'h0000_0100, 1);
        // Steering across FIFO 2 and FIFO 3
        add_step(OP_CAM, 9'h000, 4'h0, 32'h0, 11);
        add_step(OP_CAM, 9'h000, 4'h0, 32'h0, 16);
        add_step(OP_CAM, 9'h000, 4'h0, 32'h0, 4);
        add_step(OP_RDM, cam_pkg::ADR_FIFO1_FLAG, 4'hF, 32'h0, 1);
        add_step(OP_RDM, cam_pkg::ADR_FIFO2_FLAG, 4'hF, 32'h0, 1);
        add_step(OP_RDM, cam_pkg::ADR_FIFO3_FLAG, 4'hF, 32'h0, 1);
        add_step(OP_RDM, cam_pkg::ADR_FIFO2_ACC, 4'hF, 32'h0, 3);
        add_step(OP_RDM, cam_pkg::ADR_FIFO3_ACC, 4'hF, 32'h0, 2);
        // Overflow of FIFO 1 and a full wrap of the steering counter
        add_step(OP_CAM, 9'h000, 4'h0, 32'h0, 12);
        add_step(OP_CAM, 9'h000, 4'h0, 32'h0, 16);
        add_step(OP_RD, cam_pkg::ADR_FIFO1_FLAG, 4'hF, 32'h0000_0610, 1);
        add_step(OP_CAM, 9'h000, 4'h0, 32'h0, 36);
        add_step(OP_RDM, cam_pkg::ADR_FIFO1_ACC, 4'hF, 32'h0, 16);
        add_step(OP_RD, cam_pkg::ADR_FIFO1_FLAG, 4'hF, 32'h0000_0500, 1);
        add_step(OP_RDM, cam_pkg::ADR_FIFO2_FLAG, 4'hF, 32'h0, 1);
        add_step(OP_RDM, cam_pkg::ADR_FIFO3_ACC, 4'hF, 32'h0, 16);
        add_step(OP_RDM, cam_pkg::ADR_FIFO3_FLAG, 4'hF, 32'h0, 1);

        repeat (16) @(posedge PCLKI);
        #1;
        WBs_RST_i = 1'b0;
        check_value("wbs_ack_o", 32'(wbs_ack_o), 32'h0);
        check_value("device_id_o", device_id_o, cam_pkg::DEVICE_ID);

        foreach (steps[s])
        begin
            st = steps[s];
            case (st.op)
                OP_WR:   bus_cycle(st.adr, 1'b1, st.strb, st.dat, rdata);
                OP_RD:
                begin
                    bus_cycle(st.adr, 1'b0, 4'hF, 32'h0, rdata);
                    check_value($sformatf("wbs_dat_o @0x%03h", st.adr), rdata, st.dat);
                end
                OP_RDM:
                    for (int r = 0; r < int'(st.n); r++)
                    begin
                        model_read(st.adr, expv);
                        bus_cycle(st.adr, 1'b0, 4'hF, 32'h0, rdata);
                        check_value($sformatf("wbs_dat_o @0x%03h", st.adr), rdata, expv);
                    end
                OP_CAM:  cam_burst(int'(st.n));
                OP_GPIO:
                begin
                    check_value("gpio_out_o", 32'(gpio_out_o), {24'h0, st.dat[7:0]});
                    check_value("gpio_oe_o", 32'(gpio_oe_o), {24'h0, st.dat[15:8]});
                end
                default: stop_run("unknown operation in the stimulus table");
            endcase
        end

        // Let the last ack settle past the bound checks
        repeat (2) @(posedge PCLKI);
        #1;

        if (bound_check_failed())
            stop_run("a bound assertion on the bus or on a FIFO failed");
        else
        begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

//--- files.f
cam_pkg.sv
pixel_packer.sv
word_fifo.sv
fifo_bank.sv
wb_regs.sv
cam_fifo_top.sv
tb_cam_fifo_assert.sv
tb_cam_fifo.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
LINTFLAGS = --lint-only --timing --assert
TOP       = tb_cam_fifo
FILELIST  = files.f
PASS_MSG  = ** PASS **
SIM_BIN   = obj_dir/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(SIM_BIN) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf obj_dir
